/* armPipePkg.sv */
package armPipePkg;

  typedef logic [31:0] dataT;    // Datapath word
  typedef logic [3:0]  regAddrT; // Register number R0..R15
  typedef logic [3:0]  flagsT;   // N Z C V, N in bit 3

  typedef enum logic [1:0] {
    aluAdd = 2'b00,
    aluSub = 2'b01,
    aluAnd = 2'b10,
    aluOrr = 2'b11
  } aluCtrlT;

  // Immediate formats
  typedef enum logic [1:0] {
    immDp  = 2'b00, // imm8, zero-extended
    immMem = 2'b01, // imm12, zero-extended
    immBr  = 2'b10  // imm24, sign-extended, word offset
  } immSrcT;

  // Operand source in execute
  typedef enum logic [1:0] {
    fwdReg  = 2'b00, // Value read in decode
    fwdResW = 2'b01, // Writeback result
    fwdAluM = 2'b10  // ALU output in memory stage
  } fwdSelT;

  typedef union packed {
    struct packed {
      logic [3:0] cond;
      logic [7:0] op;
      logic [3:0] rn;
      logic [3:0] rd;
      logic [3:0] rs;
      logic [7:0] imm8; // Low nibble doubles as rm
    } dp;
    struct packed {
      logic [3:0]  cond;
      logic [3:0]  op;
      logic [23:0] imm24;
    } br;
  } instrT;

  localparam regAddrT PC_REG  = 4'd15;
  localparam dataT    PC_STEP = 32'd4;

endpackage

/* stageAddrIf.sv */
interface stageAddrIf;
  import armPipePkg::*;

  regAddrT ra1D; // Sources in decode
  regAddrT ra2D;
  regAddrT ra1E; // Sources in execute
  regAddrT ra2E;
  regAddrT waE;  // Destination as it moves down the pipe
  regAddrT waM;
  regAddrT waW;

  modport decode (
    output ra1D, ra2D, ra1E, ra2E, waE
  );

  modport execute (
    input  waE,
    output waM
  );

  modport writeback (
    input  waM,
    output waW
  );

  // Comparators see every stage
  modport hazard (
    input ra1D, ra2D, ra1E, ra2E, waE, waM, waW
  );

endinterface

/* fetchStage.sv */
module fetchStage #(
  parameter armPipePkg::dataT resetPc = 32'h0000_0000
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             stallF,
  input  logic             branchTakenE,
  input  logic             pcSrcW,
  input  armPipePkg::dataT aluResultE, // Branch target
  input  armPipePkg::dataT resultW,    // Write to PC from writeback
  output armPipePkg::dataT pcF,
  output armPipePkg::dataT pcPlus4F
);
  import armPipePkg::*;

  dataT pcNextF;

  assign pcPlus4F = pcF + PC_STEP;

  // Branch in execute wins over a PC write in writeback
  always_comb begin
    if (branchTakenE) pcNextF = aluResultE;
    else if (pcSrcW)  pcNextF = resultW;
    else              pcNextF = pcPlus4F;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= resetPc;
    end else if (!stallF) begin
      pcF <= pcNextF; // Hold while stalled
    end
  end

endmodule

/* registerFile.sv */
module registerFile (
  input  logic                clk,
  input  logic                rstN,
  input  logic                we,
  input  armPipePkg::regAddrT ra1,
  input  armPipePkg::regAddrT ra2,
  input  armPipePkg::regAddrT wa,
  input  armPipePkg::dataT    wd,
  input  armPipePkg::dataT    r15, // PC+8, not stored here
  output armPipePkg::dataT    rd1,
  output armPipePkg::dataT    rd2
);
  import armPipePkg::*;

  dataT regs [0:PC_REG-1]; // R0..R14

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < PC_REG; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != PC_REG) begin
      regs[wa] <= wd; // Writes to R15 dropped
    end
  end

  // Plain read, a write shows up next cycle
  assign rd1 = (ra1 == PC_REG) ? r15 : regs[ra1];
  assign rd2 = (ra2 == PC_REG) ? r15 : regs[ra2];

endmodule

/* decodeStage.sv */
module decodeStage (
  input  logic                clk,
  input  logic                rstN,
  input  logic                stallD,
  input  logic                flushD,
  input  logic [1:0]          regSrcD,  // Bit 0 reads PC, bit 1 reads rd
  input  armPipePkg::immSrcT  immSrcD,
  input  armPipePkg::dataT    instrF,
  input  armPipePkg::dataT    pcPlus4F, // PC+8 of the word in decode
  input  logic                regWriteW,
  input  armPipePkg::regAddrT waW,
  input  armPipePkg::dataT    resultW,
  output armPipePkg::dataT    instrD,
  output armPipePkg::dataT    rd1E,
  output armPipePkg::dataT    rd2E,
  output armPipePkg::dataT    extImmE,
  stageAddrIf.decode          addr
);
  import armPipePkg::*;

  instrT instrU;
  dataT  rd1D;
  dataT  rd2D;
  dataT  extImmD;

  // Flush beats stall
  always_ff @(posedge clk) begin
    if (!rstN || flushD) begin
      instrD <= '0;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  assign instrU = instrD;

  assign addr.ra1D = regSrcD[0] ? PC_REG : instrU.dp.rn;
  assign addr.ra2D = regSrcD[1] ? instrU.dp.rd : instrU.dp.imm8[3:0]; // rd for stores, else rm

  registerFile regFile (
    .clk  (clk),
    .rstN (rstN),
    .we   (regWriteW),
    .ra1  (addr.ra1D),
    .ra2  (addr.ra2D),
    .wa   (waW),
    .wd   (resultW),
    .r15  (pcPlus4F),
    .rd1  (rd1D),
    .rd2  (rd2D)
  );

  always_comb begin
    case (immSrcD)
      immDp:   extImmD = {24'b0, instrU.dp.imm8};
      immMem:  extImmD = {20'b0, instrU.dp.rs, instrU.dp.imm8}; // Full 12-bit offset
      immBr:   extImmD = {{6{instrU.br.imm24[23]}}, instrU.br.imm24, 2'b00};
      default: extImmD = '0;
    endcase
  end

  // Decode to execute, no stall here
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rd1E      <= '0;
      rd2E      <= '0;
      extImmE   <= '0;
      addr.ra1E <= '0;
      addr.ra2E <= '0;
      addr.waE  <= '0;
    end else begin
      rd1E      <= rd1D;
      rd2E      <= rd2D;
      extImmE   <= extImmD;
      addr.ra1E <= addr.ra1D;
      addr.ra2E <= addr.ra2D;
      addr.waE  <= instrU.dp.rd;
    end
  end

endmodule

/* armAlu.sv */
module armAlu (
  input  armPipePkg::dataT    a,
  input  armPipePkg::dataT    b,
  input  armPipePkg::aluCtrlT ctrl,
  output armPipePkg::dataT    result,
  output armPipePkg::flagsT   flags
);
  import armPipePkg::*;

  logic        isSub;
  logic        isArith;
  dataT        bOp;
  logic [32:0] sum;
  logic        carry;
  logic        overflow;

  assign isSub   = (ctrl == aluSub);
  assign isArith = (ctrl == aluAdd) || isSub;
  assign bOp     = isSub ? ~b : b;         // a - b as a + ~b + 1
  assign sum     = {1'b0, a} + {1'b0, bOp} + {32'b0, isSub};

  assign carry    = sum[32];               // On subtract this is no-borrow
  assign overflow = (a[31] == bOp[31]) && (sum[31] != a[31]);

  always_comb begin
    case (ctrl)
      aluAdd,
      aluSub:  result = sum[31:0];
      aluAnd:  result = a & b;
      default: result = a | b;
    endcase
  end

  // Logic ops leave C and V clear
  assign flags = {result[31], result == '0, isArith & carry, isArith & overflow};

endmodule

/* executeStage.sv */
module executeStage (
  input  logic                clk,
  input  logic                rstN,
  input  armPipePkg::dataT    rd1E,
  input  armPipePkg::dataT    rd2E,
  input  armPipePkg::dataT    extImmE,
  input  logic                aluSrcE,     // Immediate as operand B
  input  armPipePkg::aluCtrlT aluControlE,
  input  armPipePkg::fwdSelT  forwardAE,
  input  armPipePkg::fwdSelT  forwardBE,
  input  armPipePkg::dataT    resultW,
  output armPipePkg::dataT    aluResultE,
  output armPipePkg::flagsT   aluFlagsE,
  output armPipePkg::dataT    aluOutM,
  output armPipePkg::dataT    writeDataM,
  stageAddrIf.execute         addr
);
  import armPipePkg::*;

  dataT srcAE;
  dataT srcBE;
  dataT writeDataE;

  // Bypass from memory or writeback
  function automatic dataT fwdMux(input fwdSelT sel, input dataT regVal,
                                  input dataT resW, input dataT aluM);
    case (sel)
      fwdResW: return resW;
      fwdAluM: return aluM;
      default: return regVal;
    endcase
  endfunction

  assign srcAE      = fwdMux(forwardAE, rd1E, resultW, aluOutM);
  assign writeDataE = fwdMux(forwardBE, rd2E, resultW, aluOutM); // Also store data
  assign srcBE      = aluSrcE ? extImmE : writeDataE;

  armAlu alu (
    .a      (srcAE),
    .b      (srcBE),
    .ctrl   (aluControlE),
    .result (aluResultE),
    .flags  (aluFlagsE)
  );

  // Execute to memory
  always_ff @(posedge clk) begin
    if (!rstN) begin
      aluOutM    <= '0;
      writeDataM <= '0;
      addr.waM   <= '0;
    end else begin
      aluOutM    <= aluResultE;
      writeDataM <= writeDataE;
      addr.waM   <= addr.waE;
    end
  end

endmodule

/* writebackStage.sv */
module writebackStage (
  input  logic             clk,
  input  logic             rstN,
  input  armPipePkg::dataT aluOutM,
  input  armPipePkg::dataT readDataM, // From data memory
  input  logic             memToRegW,
  output armPipePkg::dataT resultW,
  stageAddrIf.writeback    addr
);
  import armPipePkg::*;

  dataT aluOutW;
  dataT readDataW;

  // Memory to writeback
  always_ff @(posedge clk) begin
    if (!rstN) begin
      aluOutW   <= '0;
      readDataW <= '0;
      addr.waW  <= '0;
    end else begin
      aluOutW   <= aluOutM;
      readDataW <= readDataM;
      addr.waW  <= addr.waM;
    end
  end

  // Load data or ALU result
  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

/* hazardMatch.sv */
module hazardMatch (
  stageAddrIf.hazard addr,
  output logic       match1EM,
  output logic       match1EW,
  output logic       match2EM,
  output logic       match2EW,
  output logic       match12DE
);

  // Operand A in execute against later destinations
  assign match1EM = (addr.waM == addr.ra1E);
  assign match1EW = (addr.waW == addr.ra1E);

  // Operand B, store data included
  assign match2EM = (addr.waM == addr.ra2E);
  assign match2EW = (addr.waW == addr.ra2E);

  // Load-use check, execute destination against decode sources
  assign match12DE = (addr.waE == addr.ra1D) || (addr.waE == addr.ra2D);

endmodule

/* armDatapath.sv */
module armDatapath #(
  parameter armPipePkg::dataT resetPc = 32'h0000_0000
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic [1:0]          regSrcD,
  input  armPipePkg::immSrcT  immSrcD,
  input  logic                aluSrcE,
  input  armPipePkg::aluCtrlT aluControlE,
  input  logic                branchTakenE,
  input  logic                memToRegW,
  input  logic                pcSrcW,
  input  logic                regWriteW,
  input  armPipePkg::dataT    instrF,
  input  armPipePkg::dataT    readDataM,
  input  armPipePkg::fwdSelT  forwardAE,
  input  armPipePkg::fwdSelT  forwardBE,
  input  logic                stallF,
  input  logic                stallD,
  input  logic                flushD,
  output armPipePkg::dataT    pcF,
  output armPipePkg::dataT    instrD,
  output armPipePkg::dataT    aluOutM,    // Data memory address
  output armPipePkg::dataT    writeDataM, // Store data
  output armPipePkg::flagsT   aluFlagsE,
  output logic                match1EM,
  output logic                match1EW,
  output logic                match2EM,
  output logic                match2EW,
  output logic                match12DE
);
  import armPipePkg::*;

  dataT pcPlus4F;
  dataT resultW;
  dataT aluResultE;
  dataT rd1E;
  dataT rd2E;
  dataT extImmE;

  stageAddrIf addrBus ();

  fetchStage #(.resetPc(resetPc)) fetch (
    .clk, .rstN, .stallF, .branchTakenE, .pcSrcW,
    .aluResultE, .resultW, .pcF, .pcPlus4F
  );

  decodeStage decode (
    .clk, .rstN, .stallD, .flushD, .regSrcD, .immSrcD, .instrF, .pcPlus4F,
    .regWriteW, .waW(addrBus.waW), .resultW, .instrD, .rd1E, .rd2E, .extImmE,
    .addr(addrBus.decode)
  );

  executeStage execute (
    .clk, .rstN, .rd1E, .rd2E, .extImmE, .aluSrcE, .aluControlE, .forwardAE,
    .forwardBE, .resultW, .aluResultE, .aluFlagsE, .aluOutM, .writeDataM,
    .addr(addrBus.execute)
  );

  writebackStage writeback (
    .clk, .rstN, .aluOutM, .readDataM, .memToRegW, .resultW,
    .addr(addrBus.writeback)
  );

  hazardMatch matcher (
    .addr(addrBus.hazard),
    .match1EM, .match1EW, .match2EM, .match2EW, .match12DE
  );

endmodule

/* tbArmDatapath.sv */
module tbArmDatapath;
  timeunit 1ns;
  timeprecision 100ps;
  import armPipePkg::*;

  localparam int   CLK_PERIOD = 40;
  localparam dataT RESET_PC   = 32'h0000_0100;
  localparam int   PIPE_DEPTH = 5;
  localparam int   NUM_TESTS  = 60; // Upper bound on instructions scheduled
  localparam int   NUM_SEL    = 6;  // Observed outputs in observed()

  logic       clk;
  logic       rstN;
  logic [1:0] regSrcD;
  immSrcT     immSrcD;
  logic       aluSrcE;
  aluCtrlT    aluControlE;
  logic       branchTakenE;
  logic       memToRegW;
  logic       pcSrcW;
  logic       regWriteW;
  dataT       instrF;
  dataT       readDataM;
  fwdSelT     forwardAE;
  fwdSelT     forwardBE;
  logic       stallF;
  logic       stallD;
  logic       flushD;
  dataT       pcF;
  dataT       instrD;
  dataT       aluOutM;
  dataT       writeDataM;
  flagsT      aluFlagsE;
  logic       match1EM;
  logic       match1EW;
  logic       match2EM;
  logic       match2EW;
  logic       match12DE;

  int   seed = 64;
  int   cycleCnt;           // Rising edges since reset release
  dataT pcExp;              // Expected fetch PC
  dataT brTarget;           // Branch target of the op in execute
  dataT psTarget;           // PC write value of the op in writeback
  dataT model [0:14];       // Register file model for R0..R14
  int   expCyc [NUM_SEL];   // Cycle in which each output is checked
  dataT expVal [NUM_SEL];

  armDatapath #(.resetPc(RESET_PC)) armDatapath_inst (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Expected NZCV above the result word
  function automatic logic [35:0] refAlu(input dataT a, input dataT b, input aluCtrlT ctrl);
    logic [32:0] wide;
    dataT        r;
    logic        c;
    logic        v;
    c = 1'b0;
    v = 1'b0;
    case (ctrl)
      aluAdd: begin
        wide = {1'b0, a} + {1'b0, b};
        r    = wide[31:0];
        c    = wide[32];
        v    = (a[31] == b[31]) && (r[31] != a[31]); // Same signs in, other sign out
      end
      aluSub: begin
        r = a - b;
        c = (a >= b); // No borrow
        v = (a[31] != b[31]) && (r[31] != a[31]);
      end
      aluAnd:  r = a & b;
      default: r = a | b;
    endcase
    return {r[31], r == 32'd0, c, v, r};
  endfunction

  // Immediate built from the instruction bits
  function automatic dataT extendImm(input dataT word, input immSrcT sel);
    case (sel)
      immMem:  return {20'b0, word[11:0]};
      immBr:   return {{6{word[23]}}, word[23:0], 2'b00};
      default: return {24'b0, word[7:0]};
    endcase
  endfunction

  function automatic dataT observed(input int sel);
    case (sel)
      0:       return pcF;
      1:       return aluOutM;
      2:       return writeDataM;
      3:       return instrD;
      4:       return {28'b0, aluFlagsE};
      default: return {27'b0, match1EM, match1EW, match2EM, match2EW, match12DE};
    endcase
  endfunction

  function automatic string sigName(input int sel);
    case (sel)
      0:       return "pcF";
      1:       return "aluOutM";
      2:       return "writeDataM";
      3:       return "instrD";
      4:       return "aluFlagsE";
      default: return "match outputs";
    endcase
  endfunction

  // Data-processing word with rm in imm8[3:0]
  function automatic dataT dpWord(input regAddrT rn, input regAddrT rd, input logic [7:0] imm8);
    return {4'hE, 8'h28, rn, rd, 4'h3, imm8};
  endfunction

  function automatic dataT readModel(input regAddrT a);
    return (a == PC_REG) ? pcExp + PC_STEP : model[a]; // R15 is PC+8 in decode
  endfunction

  task automatic randWord(output dataT v);
    v = $random(seed);
  endtask

  task automatic randReg(input int lim, output regAddrT r);
    logic [31:0] t;
    t = $random(seed);
    r = regAddrT'(t % lim);
  endtask

  task automatic expectAt(input int sel, input dataT val);
    expCyc[sel] = cycleCnt;
    expVal[sel] = val;
  endtask

  // One clock while the PC model follows the inputs live before the edge
  task automatic tick();
    @(posedge clk);
    cycleCnt++;
    if (!stallF) begin
      if (branchTakenE) pcExp = brTarget;
      else if (pcSrcW)  pcExp = psTarget;
      else              pcExp = pcExp + PC_STEP;
    end
    expectAt(0, pcExp);
  endtask

  // One instruction alone through all five stages
  task automatic runOp(input aluCtrlT ctrl, input regAddrT rn, input regAddrT rd,
                       input logic [7:0] imm8, input logic useImm, input logic [1:0] regSrc,
                       input immSrcT imm, input logic ld, input dataT ldData,
                       input logic br, input logic ps);
    dataT        a;
    dataT        bReg;
    dataT        b;
    logic [35:0] expRes;
    dataT        wval;
    tick();
    instrF <= dpWord(rn, rd, imm8);
    tick();
    instrF  <= '0;
    regSrcD <= regSrc; // Decode
    immSrcD <= imm;
    a      = readModel(regSrc[0] ? PC_REG : rn);
    bReg   = readModel(regSrc[1] ? rd : imm8[3:0]);
    b      = useImm ? extendImm(dpWord(rn, rd, imm8), imm) : bReg;
    expRes = refAlu(a, b, ctrl);
    tick();
    regSrcD      <= 2'b00;
    immSrcD      <= immDp;
    aluSrcE      <= useImm; // Execute
    aluControlE  <= ctrl;
    branchTakenE <= br;
    brTarget = expRes[31:0];
    expectAt(4, {28'b0, expRes[35:32]});
    tick();
    aluSrcE      <= 1'b0;
    aluControlE  <= aluAdd;
    branchTakenE <= 1'b0;
    readDataM    <= ldData; // Memory
    expectAt(1, expRes[31:0]);
    expectAt(2, bReg);
    tick();
    readDataM <= '0;
    memToRegW <= ld;        // Writeback
    regWriteW <= 1'b1;
    pcSrcW    <= ps;
    wval     = ld ? ldData : expRes[31:0];
    psTarget = wval;
    tick();
    memToRegW <= 1'b0;
    regWriteW <= 1'b0;
    pcSrcW    <= 1'b0;
    if (rd != PC_REG) model[rd] = wval;
  endtask

  // Three back-to-back ops with R5 bypassed from memory and then from writeback
  task automatic forwardTest();
    logic [35:0] r1;
    logic [35:0] r2;
    logic [35:0] r3;
    tick();
    instrF <= dpWord(4'd1, 4'd5, 8'h02);
    tick();
    instrF <= dpWord(4'd5, 4'd6, 8'h03);
    r1 = refAlu(model[1], model[2], aluAdd);
    tick();
    instrF      <= dpWord(4'd4, 4'd7, 8'h05);
    aluControlE <= aluAdd;
    expectAt(4, {28'b0, r1[35:32]});
    r2 = refAlu(r1[31:0], model[3], aluSub);
    tick();
    instrF      <= '0;
    aluControlE <= aluSub;
    forwardAE   <= fwdAluM;
    expectAt(4, {28'b0, r2[35:32]});
    expectAt(1, r1[31:0]);
    r3 = refAlu(model[4], r1[31:0], aluOrr);
    tick();
    aluControlE <= aluOrr;
    forwardAE   <= fwdReg;
    forwardBE   <= fwdResW;
    regWriteW   <= 1'b1; // First op in writeback
    expectAt(4, {28'b0, r3[35:32]});
    expectAt(1, r2[31:0]);
    tick();
    aluControlE <= aluAdd;
    forwardBE   <= fwdReg;
    model[5] = r1[31:0];
    expectAt(1, r3[31:0]);
    expectAt(2, r1[31:0]); // Store data takes the bypass too
    tick();
    model[6] = r2[31:0];
    tick();
    regWriteW <= 1'b0;
    model[7] = r3[31:0];
  endtask

  task automatic decodeTest();
    tick();
    instrF <= dpWord(4'd2, 4'd3, 8'h04);
    tick();
    instrF <= dpWord(4'd6, 4'd8, 8'h09);
    stallD <= 1'b1;
    expectAt(3, dpWord(4'd2, 4'd3, 8'h04));
    tick();
    flushD <= 1'b1; // Flush while still stalled
    expectAt(3, dpWord(4'd2, 4'd3, 8'h04));
    tick();
    flushD <= 1'b0;
    stallD <= 1'b0;
    instrF <= '0;
    expectAt(3, '0);
    tick();
    expectAt(3, '0);
  endtask

  task automatic matchTest();
    regAddrT d1;
    regAddrT d2;
    regAddrT dRd;
    regAddrT e1;
    regAddrT e2;
    regAddrT wE;
    regAddrT wM;
    regAddrT wW;
    regAddrT rn;
    regAddrT rm;
    regAddrT rd;
    dataT    prev;
    repeat (4) tick(); // Drain to zero addresses
    {d1, d2, dRd, e1, e2, wE, wM, wW} = '0;
    prev = '0;
    for (int i = 0; i < 12; i++) begin
      tick();
      wW  = wM;
      wM  = wE;
      wE  = dRd;
      e1  = d1;
      e2  = d2;
      d1  = prev[19:16];
      d2  = prev[3:0];
      dRd = prev[15:12];
      expectAt(5, {27'b0, e1 == wM, e1 == wW, e2 == wM, e2 == wW, (wE == d1) || (wE == d2)});
      randReg(4, rn); // Small range so matches happen often
      randReg(4, rm);
      randReg(4, rd);
      prev = dpWord(rn, rd, {4'h0, rm});
      instrF <= prev;
    end
  endtask

  // Compares every output that has an expectation for this cycle
  always @(negedge clk) begin
    for (int i = 0; i < NUM_SEL; i++) begin
      if (expCyc[i] == cycleCnt) begin
        assert (observed(i) == expVal[i]) else begin
          $display("Fail at %0d ns: %s is %h, expected %h",
                   $time, sigName(i), observed(i), expVal[i]);
          $display("TESTS FAILED");
          $fatal(1, "Output mismatch");
        end
      end
    end
  end

  initial begin
    #(NUM_TESTS * PIPE_DEPTH * 2 * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("TESTS FAILED");
    $fatal(1, "Timeout");
  end

  initial begin
    dataT    v;
    aluCtrlT ctrl;
    immSrcT  imm;
    regAddrT rn;
    regAddrT rd;
    rstN         = 1'b0;
    regSrcD      = 2'b00;
    immSrcD      = immDp;
    aluSrcE      = 1'b0;
    aluControlE  = aluAdd;
    branchTakenE = 1'b0;
    memToRegW    = 1'b0;
    pcSrcW       = 1'b0;
    regWriteW    = 1'b0;
    instrF       = '0;
    readDataM    = '0;
    forwardAE    = fwdReg;
    forwardBE    = fwdReg;
    stallF       = 1'b0;
    stallD       = 1'b0;
    flushD       = 1'b0;
    cycleCnt     = 0;
    brTarget     = '0;
    psTarget     = '0;
    for (int i = 0; i < NUM_SEL; i++) expCyc[i] = -1;
    for (int i = 0; i < 15; i++) model[i] = '0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    pcExp = RESET_PC;
    expectAt(0, pcExp);
    // Free-running fetch and then a stall
    repeat (3) tick();
    stallF <= 1'b1;
    repeat (3) tick();
    stallF <= 1'b0;
    tick();
    // Loads fill R1..R14 while R0 stays zero
    for (int r = 1; r < 15; r++) begin
      randWord(v);
      runOp(aluAdd, 4'd0, regAddrT'(r), 8'h00, 1'b1, 2'b00, immMem, 1'b1, v, 1'b0, 1'b0);
    end
    for (int i = 0; i < 20; i++) begin
      randWord(v);
      ctrl = aluCtrlT'(v[1:0]);
      imm  = (v[17:16] == 2'b11) ? immDp : immSrcT'(v[17:16]);
      randReg(15, rn);
      randReg(14, rd);
      rd = rd + 4'd1;
      runOp(ctrl, rn, rd, v[15:8], v[2], 2'b00, imm, 1'b0, '0, 1'b0, 1'b0);
    end
    // rd as source
    runOp(aluAdd, 4'd2, 4'd12, 8'h0C, 1'b0, 2'b10, immDp, 1'b0, '0, 1'b0, 1'b0);
    // Reads R15
    runOp(aluAdd, 4'd0, 4'd13, 8'h00, 1'b1, 2'b01, immDp, 1'b0, '0, 1'b0, 1'b0);
    // Branch relative to PC+8
    runOp(aluAdd, 4'd0, PC_REG, 8'h40, 1'b1, 2'b01, immBr, 1'b0, '0, 1'b1, 1'b0);
    // PC write
    runOp(aluOrr, 4'd0, PC_REG, 8'h80, 1'b1, 2'b00, immDp, 1'b0, '0, 1'b0, 1'b1);
    forwardTest();
    decodeTest();
    matchTest();
    tick();
    tick();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* armDatapath.f */
armPipePkg.sv
stageAddrIf.sv
fetchStage.sv
registerFile.sv
decodeStage.sv
armAlu.sv
executeStage.sv
writebackStage.sv
hazardMatch.sv
armDatapath.sv
tbArmDatapath.sv

/* runSim.sh */
#!/bin/sh
# Build and run; a $fatal in the testbench gives a non-zero exit status
verilator --binary --timing -f armDatapath.f --top-module tbArmDatapath -o simArmDatapath \
  && ./obj_dir/simArmDatapath \
  || exit 1
